// ==== abc_ram.f ====
verilog/abc_ram_pkg.sv
verilog/ram_write_port.sv
verilog/ram_bank.sv
verilog/ram_read_port.sv
verilog/abc_ram.sv
verification/abc_ram_props.sv
verification/abc_ram_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --top-module abc_ram_tb -f abc_ram.f -o abc_ram_sim
./obj_dir/abc_ram_sim | tee "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi
echo "Simulation finished without failure"

// ==== verification/abc_ram_tb.sv ====
`default_nettype none

module abc_ram_tb
    import abc_ram_pkg::*;
();

    localparam int DATA_WIDTH  = 16;
    localparam int WORDS       = 2 ** ADDR_WIDTH;
    localparam int TEST_CYCLES = 3 + 1 + 2 * WORDS + 12 + 8 + 500 + 4;
    localparam int TIMEOUT     = TEST_CYCLES * 8 + 400;

    typedef logic [DATA_WIDTH-1:0] data_t;
    // sb_correct in the upper bit and db_detect in the lower
    typedef logic [1:0] flags_t;

    logic       CLK = 1'b0;
    logic       rst_n;
    logic       we;
    addr_t      addr;
    data_t      wdata;
    logic [1:0] inject;
    data_t      rdata;
    logic       sb_correct;
    logic       db_detect;

    // Reference memory of clean data plus the injected flips per word
    data_t      shadow_mem   [WORDS];
    logic [1:0] shadow_tag   [WORDS];
    logic       shadow_known [WORDS];

    // Expectations waiting for their output cycle
    int     due_q  [$];
    string  name_q [$];
    data_t  data_q [$];
    flags_t flag_q [$];
    logic   chk_q  [$];

    integer seed;
    int     neg_count   = 0;
    int     data_errors = 0;
    int     flag_errors = 0;
    int     misc_errors = 0;

    abc_ram #(
        .DATA_WIDTH (DATA_WIDTH),
        .ECC_EN     (1)
    ) uut (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .we         (we),
        .addr       (addr),
        .wdata      (wdata),
        .inject     (inject),
        .rdata      (rdata),
        .sb_correct (sb_correct),
        .db_detect  (db_detect)
    );

    always #4 CLK = ~CLK;

    //----------------------------------------------------------------------
    // Reference model predicts this cycle's read, then applies the write
    //----------------------------------------------------------------------
    function automatic void model_step(input logic w, input addr_t a, input data_t d,
                                       input logic [1:0] inj, output logic known,
                                       output data_t exp_d, output flags_t exp_f,
                                       output logic chk_d);
        addr_t ra;
        ra    = w ? {a[ADDR_WIDTH-1:1], ~a[0]} : a;
        known = shadow_known[ra];
        exp_d = shadow_mem[ra];
        chk_d = 1'b1;
        case (shadow_tag[ra])
            2'b00:   exp_f = 2'b00;
            // Two flipped bits leave the data unrecoverable
            2'b11:
            begin
                exp_f = 2'b01;
                chk_d = 1'b0;
            end
            default: exp_f = 2'b10;
        endcase
        if (w)
        begin
            shadow_mem[a]   = d;
            shadow_tag[a]   = inj;
            shadow_known[a] = 1'b1;
        end
    endfunction

    task automatic compare_data(input string name, input data_t exp, input data_t act);
        if (exp !== act)
        begin
            $display("ERROR %s: expected rdata %h, actual %h", name, exp, act);
            data_errors++;
        end
    endtask

    task automatic compare_flags(input string name, input flags_t exp, input flags_t act);
        if (exp !== act)
        begin
            $display("ERROR %s: expected flags %b, actual %b", name, exp, act);
            flag_errors++;
        end
    endtask

    task automatic drive_cycle(input string name, input logic w, input addr_t a,
                               input data_t d, input logic [1:0] inj);
        logic   known;
        data_t  exp_d;
        flags_t exp_f;
        logic   chk_d;
        @(posedge CLK);
        we     <= w;
        addr   <= a;
        wdata  <= d;
        inject <= inj;
        model_step(w, a, d, inj, known, exp_d, exp_f, chk_d);
        if (known)
        begin
            // Sampled at the next edge and visible at the negedge after it
            due_q.push_back(neg_count + 2);
            name_q.push_back(name);
            data_q.push_back(exp_d);
            flag_q.push_back(exp_f);
            chk_q.push_back(chk_d);
        end
    endtask

    // Compare at the falling edge where outputs are stable
    always @(negedge CLK)
    begin
        neg_count++;
        if (due_q.size() > 0 && due_q[0] == neg_count)
        begin
            if (chk_q[0])
            begin
                compare_data(name_q[0], data_q[0], rdata);
            end
            compare_flags(name_q[0], flag_q[0], {sb_correct, db_detect});
            void'(due_q.pop_front());
            void'(name_q.pop_front());
            void'(data_q.pop_front());
            void'(flag_q.pop_front());
            void'(chk_q.pop_front());
        end
    end

    // Watchdog
    initial
    begin
        #(TIMEOUT);
        $display("Timeout: the tests did not finish within %0d time units", TIMEOUT);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        logic [31:0] r;
        logic [31:0] rd;
        seed   = 32'he804;
        rst_n  <= 1'b0;
        we     <= 1'b0;
        addr   <= '0;
        wdata  <= '0;
        inject <= 2'b00;
        for (int i = 0; i < WORDS; i++)
        begin
            shadow_mem[i]   = '0;
            shadow_tag[i]   = 2'b00;
            shadow_known[i] = 1'b0;
        end

        repeat (3) @(posedge CLK);
        rst_n <= 1'b1;
        @(negedge CLK);
        compare_data("reset", '0, rdata);
        compare_flags("reset", 2'b00, {sb_correct, db_detect});

        for (int i = 0; i < WORDS; i++)
        begin
            r = $random(seed);
            drive_cycle("fill", 1'b1, addr_t'(i), r[15:0], 2'b00);
        end
        for (int i = 0; i < WORDS; i++)
        begin
            drive_cycle("readback", 1'b0, addr_t'(i), '0, 2'b00);
        end

        // Read during write, then the new word itself
        for (int i = 0; i < 6; i++)
        begin
            r = $random(seed);
            drive_cycle("rdw", 1'b1, addr_t'(127 + i * 53), r[15:0], 2'b00);
            drive_cycle("rdw", 1'b0, addr_t'(127 + i * 53), '0, 2'b00);
        end

        //------------------------------------------------------------------
        // Error injection with single and double flips in both banks
        //------------------------------------------------------------------
        drive_cycle("inject_single", 1'b1, 8'h10, 16'h5a3c, 2'b01);
        drive_cycle("inject_single", 1'b1, 8'h91, 16'hc3e7, 2'b10);
        drive_cycle("inject_double", 1'b1, 8'h22, 16'h0ff0, 2'b11);
        drive_cycle("inject_double", 1'b1, 8'ha3, 16'hbeef, 2'b11);
        drive_cycle("inject_single", 1'b0, 8'h10, '0, 2'b00);
        drive_cycle("inject_single", 1'b0, 8'h91, '0, 2'b00);
        drive_cycle("inject_double", 1'b0, 8'h22, '0, 2'b00);
        drive_cycle("inject_double", 1'b0, 8'ha3, '0, 2'b00);

        for (int i = 0; i < 500; i++)
        begin
            r  = $random(seed);
            rd = $random(seed);
            drive_cycle("random", r[0], r[15:8], rd[15:0],
                        (r[4:2] == 3'b000) ? r[6:5] : 2'b00);
        end

        drive_cycle("drain", 1'b0, 8'h00, '0, 2'b00);
        // One negedge past the last due compare
        repeat (3) @(negedge CLK);
        if (due_q.size() != 0)
        begin
            $display("Some expected results were never compared: %0d left", due_q.size());
            misc_errors++;
        end

        $display("Errors: %0d data, %0d flags, %0d other", data_errors, flag_errors,
                 misc_errors);
        if (data_errors + flag_errors + misc_errors == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/abc_ram_props.sv ====
`default_nettype none

module abc_ram_props
    import abc_ram_pkg::*;
(
    input logic       CLK,
    input logic       rst_n,
    input logic       we,
    input addr_t      addr,
    input logic [1:0] inject,
    input logic       sb_correct,
    input logic       db_detect
);

    logic [2**ADDR_WIDTH-1:0] clean;
    addr_t                    raddr;

    // Words whose last write carried no injected error
    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            clean <= '0;
        end
        else if (we)
        begin
            clean[addr] <= (inject == 2'b00);
        end
    end

    // Neighbour word is read during a write
    assign raddr = we ? {addr[ADDR_WIDTH-1:1], ~addr[0]} : addr;

    a_flags_after_reset: assert property (@(posedge CLK) !rst_n |=> !sb_correct && !db_detect)
        else $error("ECC flags set in the cycle after reset");

    a_flags_exclusive: assert property (@(posedge CLK) disable iff (!rst_n)
        !(sb_correct && db_detect))
        else $error("sb_correct and db_detect high together");

    a_clean_read: assert property (@(posedge CLK) disable iff (!rst_n)
        clean[raddr] |=> !sb_correct && !db_detect)
        else $error("ECC flag raised on a word written without injection");

endmodule

bind abc_ram abc_ram_props u_props (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .we         (we),
    .addr       (addr),
    .inject     (inject),
    .sb_correct (sb_correct),
    .db_detect  (db_detect)
);

`default_nettype wire

// ==== verilog/abc_ram.sv ====
`default_nettype none

module abc_ram
    import abc_ram_pkg::*;
#(
    parameter int DATA_WIDTH = 16,
    parameter int ECC_EN     = 1
)
(
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  we,
    input  addr_t                 addr,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [1:0]            inject,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  sb_correct,
    output logic                  db_detect
);

    localparam int CODE_WIDTH = DATA_WIDTH + ((ECC_EN != 0) ? ecc_check_bits(DATA_WIDTH) : 0);

    ram_cmd_t              cmd;
    logic [CODE_WIDTH-1:0] wcode;
    logic [CODE_WIDTH-1:0] rcode [NUM_BANKS];

    // Encode, inject and form the bank command
    ram_write_port #(
        .DATA_WIDTH (DATA_WIDTH),
        .ECC_EN     (ECC_EN)
    ) u_wr (
        .we     (we),
        .addr   (addr),
        .wdata  (wdata),
        .inject (inject),
        .cmd    (cmd),
        .wcode  (wcode)
    );

    //----------------------------------------------------------------------
    // Storage banks
    //----------------------------------------------------------------------
    for (genvar i = 0; i < NUM_BANKS; i++)
    begin : g_bank
        ram_bank #(
            .CODE_WIDTH (CODE_WIDTH),
            .BANK_INDEX (i)
        ) u_bank (
            .CLK   (CLK),
            .rst_n (rst_n),
            .cmd   (cmd),
            .wcode (wcode),
            .rcode (rcode[i])
        );
    end

    ram_read_port #(
        .DATA_WIDTH (DATA_WIDTH),
        .ECC_EN     (ECC_EN)
    ) u_rd (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .bank_sel   (cmd.bank_sel),
        .rcode_lo   (rcode[0]),
        .rcode_hi   (rcode[1]),
        .rdata      (rdata),
        .sb_correct (sb_correct),
        .db_detect  (db_detect)
    );

endmodule

`default_nettype wire

// ==== verilog/ram_read_port.sv ====
`default_nettype none

module ram_read_port
    import abc_ram_pkg::*;
#(
    parameter int DATA_WIDTH = 16,
    parameter int ECC_EN     = 1,
    localparam int CODE_WIDTH = DATA_WIDTH + ((ECC_EN != 0) ? ecc_check_bits(DATA_WIDTH) : 0)
)
(
    input  logic                  CLK,
    input  logic                  rst_n,
    input  bank_sel_t             bank_sel,
    input  logic [CODE_WIDTH-1:0] rcode_lo,
    input  logic [CODE_WIDTH-1:0] rcode_hi,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  sb_correct,
    output logic                  db_detect
);

    bank_sel_t             sel_q;
    logic [CODE_WIDTH-1:0] code;

    //----------------------------------------------------------------------
    // Bank select, delayed to line up with the bank read registers
    //----------------------------------------------------------------------
    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            sel_q <= '0;
        end
        else
        begin
            sel_q <= bank_sel;
        end
    end

    assign code = (sel_q == 1'b1) ? rcode_hi : rcode_lo;

    //----------------------------------------------------------------------
    // SECDED decode
    //----------------------------------------------------------------------
    generate
        if (ECC_EN != 0)
        begin : g_ecc
            localparam int HAM_BITS = ecc_check_bits(DATA_WIDTH) - 1;

            logic [DATA_WIDTH-1:0] data;
            logic [HAM_BITS-1:0]   syndrome;
            logic                  par_err;

            always_comb
            begin
                data     = code[DATA_WIDTH-1:0];
                syndrome = code[DATA_WIDTH +: HAM_BITS];
                for (int i = 0; i < DATA_WIDTH; i++)
                begin
                    for (int b = 0; b < HAM_BITS; b++)
                    begin
                        if (((ecc_data_pos(i) >> b) & 1) != 0)
                        begin
                            syndrome[b] = syndrome[b] ^ data[i];
                        end
                    end
                end
                // Overall parity across the whole stored codeword
                par_err = ^code;

                rdata      = data;
                sb_correct = 1'b0;
                db_detect  = 1'b0;
                if (syndrome != '0)
                begin
                    if (par_err)
                    begin
                        // Odd error count, fix the bit the syndrome points at
                        sb_correct = 1'b1;
                        for (int i = 0; i < DATA_WIDTH; i++)
                        begin
                            if (ecc_data_pos(i) == int'(syndrome))
                            begin
                                rdata[i] = ~data[i];
                            end
                        end
                    end
                    else
                    begin
                        db_detect = 1'b1;
                    end
                end
                else if (par_err)
                begin
                    // Only the parity bit itself flipped
                    sb_correct = 1'b1;
                end
            end
        end
        else
        begin : g_plain
            assign rdata      = code;
            assign sb_correct = 1'b0;
            assign db_detect  = 1'b0;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== verilog/ram_bank.sv ====
`default_nettype none

module ram_bank
    import abc_ram_pkg::*;
#(
    parameter int CODE_WIDTH = 22,
    parameter int BANK_INDEX = 0
)
(
    input  logic                  CLK,
    input  logic                  rst_n,
    input  ram_cmd_t              cmd,
    input  logic [CODE_WIDTH-1:0] wcode,
    output logic [CODE_WIDTH-1:0] rcode
);

    localparam int DEPTH = 2 ** BANK_ADDR_WIDTH;

    logic [CODE_WIDTH-1:0] mem [DEPTH];
    logic [NUM_BANKS-1:0]  we_vec;

    // One-hot write enables, this bank takes its own slot
    assign we_vec = NUM_BANKS'(cmd.we) << cmd.bank_sel;

    always_ff @(posedge CLK)
    begin
        if (we_vec[BANK_INDEX])
        begin
            mem[cmd.waddr] <= wcode;
        end
    end

    // Read register, old contents on a write edge
    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            rcode <= '0;
        end
        else
        begin
            rcode <= mem[cmd.raddr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ram_write_port.sv ====
`default_nettype none

module ram_write_port
    import abc_ram_pkg::*;
#(
    parameter int DATA_WIDTH = 16,
    parameter int ECC_EN     = 1,
    localparam int CODE_WIDTH = DATA_WIDTH + ((ECC_EN != 0) ? ecc_check_bits(DATA_WIDTH) : 0)
)
(
    input  logic                  we,
    input  addr_t                 addr,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [1:0]            inject,
    output ram_cmd_t              cmd,
    output logic [CODE_WIDTH-1:0] wcode
);

    logic [DATA_WIDTH-1:0] data_inj;

    //----------------------------------------------------------------------
    // Bank command
    //----------------------------------------------------------------------
    always_comb
    begin
        cmd.we       = we;
        cmd.bank_sel = addr[ADDR_WIDTH-1];
        cmd.waddr    = addr[BANK_ADDR_WIDTH-1:0];
        // During a write, read the neighbour word so ports never collide
        if (we)
        begin
            cmd.raddr = {addr[BANK_ADDR_WIDTH-1:1], ~addr[0]};
        end
        else
        begin
            cmd.raddr = addr[BANK_ADDR_WIDTH-1:0];
        end
    end

    // Diagnostic corruption of the two lowest data bits
    assign data_inj = wdata ^ DATA_WIDTH'(inject);

    //----------------------------------------------------------------------
    // SECDED encode, check bits taken from the clean data
    //----------------------------------------------------------------------
    generate
        if (ECC_EN != 0)
        begin : g_ecc
            localparam int HAM_BITS = ecc_check_bits(DATA_WIDTH) - 1;

            logic [HAM_BITS-1:0] ham;
            logic                parity;

            always_comb
            begin
                ham = '0;
                for (int i = 0; i < DATA_WIDTH; i++)
                begin
                    for (int b = 0; b < HAM_BITS; b++)
                    begin
                        if (((ecc_data_pos(i) >> b) & 1) != 0)
                        begin
                            ham[b] = ham[b] ^ wdata[i];
                        end
                    end
                end
                parity = ^{ham, wdata};
            end

            assign wcode = {parity, ham, data_inj};
        end
        else
        begin : g_plain
            assign wcode = data_inj;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== verilog/abc_ram_pkg.sv ====
`default_nettype none

package abc_ram_pkg;

    // Address map: two banks of 128 words, bank picked by the top bit
    localparam int ADDR_WIDTH      = 8;
    localparam int BANK_ADDR_WIDTH = 7;
    localparam int NUM_BANKS       = 2;

    typedef logic [ADDR_WIDTH-1:0]      addr_t;
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;
    typedef logic [0:0]                 bank_sel_t;

    // One command per cycle from the write port to banks and read port
    typedef struct packed {
        logic       we;
        bank_sel_t  bank_sel;
        bank_addr_t waddr;
        bank_addr_t raddr;
    } ram_cmd_t;

    // Hamming bits plus one overall parity bit
    function automatic int ecc_check_bits(input int data_width);
        int r;
        r = 1;
        while ((2 ** r) < (data_width + r + 1))
        begin
            r++;
        end
        return r + 1;
    endfunction

    // Hamming position of data bit idx, skipping the power-of-two slots
    function automatic int ecc_data_pos(input int idx);
        int cnt;
        cnt = 0;
        for (int pos = 3; pos < 64; pos++)
        begin
            if ((pos & (pos - 1)) != 0)
            begin
                if (cnt == idx)
                begin
                    return pos;
                end
                cnt++;
            end
        end
        return 0;
    endfunction

endpackage

`default_nettype wire
